/* verilog/raster_pkg.sv */
package raster_pkg;

    // Vertex coordinates are unsigned pixel positions.
    localparam int COORD_W = 8;

    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
    } vertex_t;

    // Flat shaded triangle, color is 4:4:4 RGB.
    typedef struct packed {
        vertex_t     a;
        vertex_t     b;
        vertex_t     c;
        logic [11:0] color;
    } triangle_t;

    // Last marks the final pixel of the final triangle in a frame.
    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
        logic               covered;
        logic [11:0]        color;
        logic               last;
    } pixel_t;

    typedef enum logic [1:0] {
        DRAW_IDLE,
        DRAW_BACKGROUND,
        DRAW_RASTER,
        DRAW_DONE
    } draw_state_e;

endpackage

/* verilog/tri_if.sv */
interface tri_if;
    import raster_pkg::*;

    logic      valid;
    logic      ready;
    triangle_t tri_data;
    logic      last;

    // Transfer happens when valid and ready are both high.
    modport src (
        output valid,
        output tri_data,
        output last,
        input  ready
    );

    modport dst (
        input  valid,
        input  tri_data,
        input  last,
        output ready
    );

endinterface

/* verilog/pix_if.sv */
interface pix_if;
    import raster_pkg::*;

    // Single-cycle strobe, the sink is always ready.
    logic   valid;
    pixel_t pix;

    modport src (
        output valid,
        output pix
    );

    modport dst (
        input valid,
        input pix
    );

endinterface

/* verilog/triangle_store.sv */
module triangle_store #(
    parameter int TRI_MAX = 4
) (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       load_en,
    input  logic [$clog2(TRI_MAX)-1:0] load_index,
    input  raster_pkg::triangle_t      load_tri,
    input  logic [$clog2(TRI_MAX)-1:0] rd_index,
    output raster_pkg::triangle_t      rd_tri
);
    import raster_pkg::*;

    triangle_t slots [TRI_MAX];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < TRI_MAX; i++) begin
                slots[i] <= '0;
            end
        end else if (load_en) begin
            slots[load_index] <= load_tri;
        end
    end

    // Read port is combinational.
    assign rd_tri = slots[rd_index];

endmodule

/* verilog/background_fill.sv */
module background_fill #(
    parameter int VIEW_W = 16,
    parameter int VIEW_H = 12
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              start,
    input  logic [11:0]                       color,
    output logic                              wr_en,
    output logic [$clog2(VIEW_W*VIEW_H)-1:0]  wr_addr,
    output logic [11:0]                       wr_data,
    output logic                              done
);

    localparam int ADDR_W = $clog2(VIEW_W * VIEW_H);
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(VIEW_W * VIEW_H - 1);

    logic              active;
    logic [ADDR_W-1:0] addr;
    logic [11:0]       color_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            active <= 1'b0;
            addr   <= '0;
        end else if (active) begin
            if (addr == LAST_ADDR) begin
                active <= 1'b0;
            end else begin
                addr <= addr + 1'b1;
            end
        end else if (start) begin
            active <= 1'b1;
            addr   <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (start && !active) begin
            color_q <= color;
        end
    end

    // One write per cycle while active.
    assign wr_en   = active;
    assign wr_addr = addr;
    assign wr_data = color_q;
    assign done    = active && (addr == LAST_ADDR);

endmodule

/* verilog/edge_rasterizer.sv */
module edge_rasterizer #(
    parameter int VIEW_W = 16,
    parameter int VIEW_H = 12
) (
    input logic clk,
    input logic rstn,
    tri_if.dst  tri_in,
    pix_if.src  pix_out
);
    import raster_pkg::*;

    localparam int COEF_W = 2 * COORD_W + 2;
    localparam int EVAL_W = 2 * COORD_W + 4;
    localparam logic [COORD_W-1:0] X_LIM = COORD_W'(VIEW_W - 1);
    localparam logic [COORD_W-1:0] Y_LIM = COORD_W'(VIEW_H - 1);

    // Edge function E(x, y) = a*x + b*y + c.
    typedef struct packed {
        logic signed [COEF_W-1:0] a;
        logic signed [COEF_W-1:0] b;
        logic signed [COEF_W-1:0] c;
    } edge_t;

    typedef struct packed {
        logic [COORD_W-1:0] x0;
        logic [COORD_W-1:0] x1;
        logic [COORD_W-1:0] y0;
        logic [COORD_W-1:0] y1;
        edge_t [2:0]        edges;
        logic [11:0]        color;
        logic               last;
        logic               empty;
    } setup_t;

    function automatic logic [COORD_W-1:0] min3(input logic [COORD_W-1:0] a, b, c);
        logic [COORD_W-1:0] m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic logic [COORD_W-1:0] max3(input logic [COORD_W-1:0] a, b, c);
        logic [COORD_W-1:0] m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    function automatic logic [COORD_W-1:0] clamp(input logic [COORD_W-1:0] v, lim);
        return (v > lim) ? lim : v;
    endfunction

    function automatic edge_t edge_setup(input vertex_t p, input vertex_t q);
        edge_t                    e;
        logic signed [COEF_W-1:0] px;
        logic signed [COEF_W-1:0] py;
        logic signed [COEF_W-1:0] qx;
        logic signed [COEF_W-1:0] qy;
        px  = COEF_W'(p.x);
        py  = COEF_W'(p.y);
        qx  = COEF_W'(q.x);
        qy  = COEF_W'(q.y);
        e.a = py - qy;
        e.b = qx - px;
        e.c = px * qy - qx * py;
        return e;
    endfunction

    function automatic logic signed [EVAL_W-1:0] edge_eval(input edge_t e,
                                                           input logic [COORD_W-1:0] x,
                                                           input logic [COORD_W-1:0] y);
        logic signed [EVAL_W-1:0] ea;
        logic signed [EVAL_W-1:0] eb;
        logic signed [EVAL_W-1:0] ec;
        logic signed [EVAL_W-1:0] px;
        logic signed [EVAL_W-1:0] py;
        ea = e.a;
        eb = e.b;
        ec = e.c;
        px = EVAL_W'(x);
        py = EVAL_W'(y);
        return ea * px + eb * py + ec;
    endfunction

    logic               setup_full;
    setup_t             setup_d;
    setup_t             setup_q;
    logic               busy;
    setup_t             job;
    logic [COORD_W-1:0] sx;
    logic [COORD_W-1:0] sy;
    logic               accept;
    logic               at_end;
    logic               scan_load;
    logic [COORD_W-1:0] min_x;
    logic [COORD_W-1:0] min_y;

    logic signed [EVAL_W-1:0] e0;
    logic signed [EVAL_W-1:0] e1;
    logic signed [EVAL_W-1:0] e2;

    assign tri_in.ready = !setup_full;
    assign accept       = tri_in.valid && tri_in.ready;
    assign at_end       = busy && (sx == job.x1) && (sy == job.y1);
    assign scan_load    = setup_full && (!busy || at_end);

    // Setup stage: clipped box and edge coefficients.
    always_comb begin
        min_x           = min3(tri_in.tri_data.a.x, tri_in.tri_data.b.x, tri_in.tri_data.c.x);
        min_y           = min3(tri_in.tri_data.a.y, tri_in.tri_data.b.y, tri_in.tri_data.c.y);
        setup_d.x0      = clamp(min_x, X_LIM);
        setup_d.y0      = clamp(min_y, Y_LIM);
        setup_d.x1      = clamp(max3(tri_in.tri_data.a.x, tri_in.tri_data.b.x,
                                     tri_in.tri_data.c.x), X_LIM);
        setup_d.y1      = clamp(max3(tri_in.tri_data.a.y, tri_in.tri_data.b.y,
                                     tri_in.tri_data.c.y), Y_LIM);
        setup_d.edges[0] = edge_setup(tri_in.tri_data.a, tri_in.tri_data.b);
        setup_d.edges[1] = edge_setup(tri_in.tri_data.b, tri_in.tri_data.c);
        setup_d.edges[2] = edge_setup(tri_in.tri_data.c, tri_in.tri_data.a);
        setup_d.color   = tri_in.tri_data.color;
        setup_d.last    = tri_in.last;
        // Box fully outside still yields one uncovered pixel.
        setup_d.empty   = (min_x > X_LIM) || (min_y > Y_LIM);
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            setup_full <= 1'b0;
            busy       <= 1'b0;
        end else begin
            if (accept) begin
                setup_full <= 1'b1;
            end else if (scan_load) begin
                setup_full <= 1'b0;
            end
            if (scan_load) begin
                busy <= 1'b1;
            end else if (at_end) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            setup_q <= setup_d;
        end
        if (scan_load) begin
            job <= setup_q;
            sx  <= setup_q.x0;
            sy  <= setup_q.y0;
        end else if (busy) begin
            if (sx == job.x1) begin
                sx <= job.x0;
                sy <= sy + 1'b1;
            end else begin
                sx <= sx + 1'b1;
            end
        end
    end

    // Scan stage output, covered for either winding.
    assign e0 = edge_eval(job.edges[0], sx, sy);
    assign e1 = edge_eval(job.edges[1], sx, sy);
    assign e2 = edge_eval(job.edges[2], sx, sy);

    assign pix_out.valid       = busy;
    assign pix_out.pix.x       = sx;
    assign pix_out.pix.y       = sy;
    assign pix_out.pix.covered = !job.empty &&
                                 ((e0 >= 0 && e1 >= 0 && e2 >= 0) ||
                                  (e0 <= 0 && e1 <= 0 && e2 <= 0));
    assign pix_out.pix.color   = job.color;
    assign pix_out.pix.last    = job.last && (sx == job.x1) && (sy == job.y1);

endmodule

/* verilog/draw_manager.sv */
module draw_manager #(
    parameter int VIEW_W  = 16,
    parameter int VIEW_H  = 12,
    parameter int TRI_MAX = 4
) (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               draw_start,
    input  logic                               draw_ack,
    input  logic [11:0]                        bg_color,
    input  logic [$clog2(TRI_MAX+1)-1:0]       tri_count,
    output logic [$clog2(TRI_MAX)-1:0]         rd_index,
    input  raster_pkg::triangle_t              rd_tri,
    output logic                               bg_start,
    input  logic                               bg_wr_en,
    input  logic [$clog2(VIEW_W*VIEW_H)-1:0]   bg_wr_addr,
    input  logic [11:0]                        bg_wr_data,
    input  logic                               bg_done,
    tri_if.src                                 tri_out,
    pix_if.dst                                 pix_in,
    output logic                               write_en,
    output logic [$clog2(VIEW_W*VIEW_H)-1:0]   write_addr,
    output logic [11:0]                        write_data,
    output logic                               frame_done
);
    import raster_pkg::*;

    localparam int ADDR_W = $clog2(VIEW_W * VIEW_H);
    localparam int IDX_W  = $clog2(TRI_MAX);
    localparam int CNT_W  = $clog2(TRI_MAX + 1);

    draw_state_e      state;
    draw_state_e      next_state;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] tri_idx;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= DRAW_IDLE;
            count_q  <= '0;
            tri_idx  <= '0;
            bg_start <= 1'b0;
        end else begin
            state    <= next_state;
            bg_start <= (state == DRAW_IDLE) && draw_start;
            if (state == DRAW_IDLE && draw_start) begin
                count_q <= tri_count;
                tri_idx <= '0;
            end else if (tri_out.valid && tri_out.ready) begin
                tri_idx <= tri_idx + 1'b1;
            end
        end
    end

    // Triangles are offered in slot order.
    assign rd_index         = IDX_W'(tri_idx);
    assign tri_out.tri_data = rd_tri;
    assign tri_out.valid    = (state == DRAW_RASTER) && (tri_idx < count_q);
    assign tri_out.last     = (tri_idx == count_q - 1'b1);

    always_comb begin
        next_state = state;
        write_en   = 1'b0;
        write_addr = '0;
        write_data = '0;
        frame_done = 1'b0;
        case (state)
            DRAW_IDLE: begin
                if (draw_start) begin
                    next_state = DRAW_BACKGROUND;
                end
            end
            DRAW_BACKGROUND: begin
                write_en   = bg_wr_en;
                write_addr = bg_wr_addr;
                write_data = bg_wr_data;
                if (bg_done) begin
                    next_state = (count_q == '0) ? DRAW_DONE : DRAW_RASTER;
                end
            end
            DRAW_RASTER: begin
                if (pix_in.valid) begin
                    write_en   = pix_in.pix.covered;
                    write_addr = ADDR_W'(pix_in.pix.y * VIEW_W + pix_in.pix.x);
                    write_data = pix_in.pix.color;
                    if (pix_in.pix.last) begin
                        next_state = DRAW_DONE;
                    end
                end
            end
            DRAW_DONE: begin
                frame_done = 1'b1;
                if (draw_ack) begin
                    next_state = DRAW_IDLE;
                end
            end
            default: begin
                next_state = DRAW_IDLE;
            end
        endcase
    end

endmodule

/* verilog/raster_top.sv */
module raster_top #(
    parameter int VIEW_W  = 16,
    parameter int VIEW_H  = 12,
    parameter int TRI_MAX = 4
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              load_en,
    input  logic [$clog2(TRI_MAX)-1:0]        load_index,
    input  raster_pkg::triangle_t             load_tri,
    input  logic                              draw_start,
    input  logic                              draw_ack,
    input  logic [11:0]                       bg_color,
    input  logic [$clog2(TRI_MAX+1)-1:0]      tri_count,
    output logic                              frame_done,
    output logic                              write_en,
    output logic [$clog2(VIEW_W*VIEW_H)-1:0]  write_addr,
    output logic [11:0]                       write_data
);
    import raster_pkg::*;

    localparam int ADDR_W = $clog2(VIEW_W * VIEW_H);

    logic [$clog2(TRI_MAX)-1:0] rd_index;
    triangle_t                  rd_tri;
    logic                       bg_start;
    logic                       bg_wr_en;
    logic [ADDR_W-1:0]          bg_wr_addr;
    logic [11:0]                bg_wr_data;
    logic                       bg_done;

    tri_if tri_bus ();
    pix_if pix_bus ();

    triangle_store #(
        .TRI_MAX(TRI_MAX)
    ) u_store (
        .clk       (clk),
        .rstn      (rstn),
        .load_en   (load_en),
        .load_index(load_index),
        .load_tri  (load_tri),
        .rd_index  (rd_index),
        .rd_tri    (rd_tri)
    );

    background_fill #(
        .VIEW_W(VIEW_W),
        .VIEW_H(VIEW_H)
    ) u_fill (
        .clk    (clk),
        .rstn   (rstn),
        .start  (bg_start),
        .color  (bg_color),
        .wr_en  (bg_wr_en),
        .wr_addr(bg_wr_addr),
        .wr_data(bg_wr_data),
        .done   (bg_done)
    );

    edge_rasterizer #(
        .VIEW_W(VIEW_W),
        .VIEW_H(VIEW_H)
    ) u_raster (
        .clk    (clk),
        .rstn   (rstn),
        .tri_in (tri_bus),
        .pix_out(pix_bus)
    );

    draw_manager #(
        .VIEW_W (VIEW_W),
        .VIEW_H (VIEW_H),
        .TRI_MAX(TRI_MAX)
    ) u_manager (
        .clk       (clk),
        .rstn      (rstn),
        .draw_start(draw_start),
        .draw_ack  (draw_ack),
        .bg_color  (bg_color),
        .tri_count (tri_count),
        .rd_index  (rd_index),
        .rd_tri    (rd_tri),
        .bg_start  (bg_start),
        .bg_wr_en  (bg_wr_en),
        .bg_wr_addr(bg_wr_addr),
        .bg_wr_data(bg_wr_data),
        .bg_done   (bg_done),
        .tri_out   (tri_bus),
        .pix_in    (pix_bus),
        .write_en  (write_en),
        .write_addr(write_addr),
        .write_data(write_data),
        .frame_done(frame_done)
    );

endmodule

/* dv/tb_clock.sv */
module tb_clock #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rstn
);

    // Reset is released on a falling edge.
    initial begin
        clk  = 1'b0;
        rstn = 1'b0;
        #(PERIOD * RESET_CYCLES);
        rstn = 1'b1;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

/* dv/raster_tb.sv */
module raster_tb;
    import raster_pkg::*;

    localparam int VIEW_W  = 16;
    localparam int VIEW_H  = 12;
    localparam int TRI_MAX = 4;
    localparam int NPIX    = VIEW_W * VIEW_H;
    localparam int IDX_W   = $clog2(TRI_MAX);
    localparam int CNT_W   = $clog2(TRI_MAX + 1);
    localparam int ADDR_W  = $clog2(NPIX);

    logic              clk;
    logic              rstn;
    logic              load_en;
    logic [IDX_W-1:0]  load_index;
    triangle_t         load_tri;
    logic              draw_start;
    logic              draw_ack;
    logic [11:0]       bg_color;
    logic [CNT_W-1:0]  tri_count;
    logic              frame_done;
    logic              write_en;
    logic [ADDR_W-1:0] write_addr;
    logic [11:0]       write_data;

    logic [31:0] stim [0:255];
    logic [11:0] model [NPIX];
    logic [11:0] ref_img [NPIX];
    int          mismatches = 0;
    int          other_errors = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    bit          frame_open = 1'b0;
    int          wr_count = 0;
    int          frame_bg = 0;
    int          frame_cnt = 0;

    tb_clock #(.PERIOD(100), .RESET_CYCLES(4)) u_clock (.clk(clk), .rstn(rstn));

    raster_top #(
        .VIEW_W (VIEW_W),
        .VIEW_H (VIEW_H),
        .TRI_MAX(TRI_MAX)
    ) DUT (
        .clk(clk), .rstn(rstn), .load_en(load_en), .load_index(load_index),
        .load_tri(load_tri), .draw_start(draw_start), .draw_ack(draw_ack),
        .bg_color(bg_color), .tri_count(tri_count), .frame_done(frame_done),
        .write_en(write_en), .write_addr(write_addr), .write_data(write_data)
    );

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            mismatches++;
            $display("MISMATCH at %0t: %s (got %0h, expected %0h)", $time, what, actual, expected);
        end
    endtask

    // Cross product of edge p->q with p->(x,y).
    function automatic int cross_at(input int px, py, qx, qy, x, y);
        return (qx - px) * (y - py) - (qy - py) * (x - px);
    endfunction

    task automatic paint_triangle(input int p);
        int v [7];
        int e0;
        int e1;
        int e2;
        for (int i = 0; i < 7; i++) begin
            v[i] = int'(stim[p + i]);
        end
        for (int y = 0; y < VIEW_H; y++) begin
            for (int x = 0; x < VIEW_W; x++) begin
                e0 = cross_at(v[0], v[1], v[2], v[3], x, y);
                e1 = cross_at(v[2], v[3], v[4], v[5], x, y);
                e2 = cross_at(v[4], v[5], v[0], v[1], x, y);
                if ((e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0)) begin
                    ref_img[y * VIEW_W + x] = 12'(v[6]);
                end
            end
        end
    endtask

    // Write monitor and frame bookkeeping.
    always @(posedge clk) begin
        if (rstn) begin
            cycles++;
            if (draw_start && !frame_open) begin
                frame_open = 1'b1;
                wr_count   = 0;
                frame_bg   = int'(bg_color);
                frame_cnt  = int'(tri_count);
            end
            if (write_en) begin
                if (!frame_open) begin
                    other_errors++;
                    $display("Write to address %0d came outside of a frame", write_addr);
                end
                check_value(int'(int'(write_addr) < NPIX), 1, "write address in frame buffer");
                if (int'(write_addr) < NPIX) begin
                    model[write_addr] = write_data;
                end
                if (wr_count < NPIX) begin
                    check_value(int'(write_addr), wr_count, "background write address");
                    check_value(int'(write_data), frame_bg, "background write color");
                end
                wr_count++;
            end
            if (frame_done && frame_open) begin
                frame_open = 1'b0;
                if (frame_cnt == 0) begin
                    check_value(wr_count, NPIX, "write count of an empty frame");
                end else begin
                    check_value(int'(wr_count >= NPIX), 1, "background write count");
                end
            end
            if (cycles > cycle_limit) begin
                $display("Run timed out after %0d cycles", cycles);
                $display("Verification failed");
                $finish;
            end
        end
    end

    initial begin
        int          ptr;
        int          frame;
        int          nframes;
        int          bg;
        int          count;
        int          nprobe;
        int          gap;
        int          px;
        int          py;
        int unsigned seed_dummy;
        seed_dummy = $urandom(32'h5d9a_f906);
        load_en    = 1'b0;
        load_index = '0;
        load_tri   = '0;
        draw_start = 1'b0;
        draw_ack   = 1'b0;
        bg_color   = '0;
        tri_count  = '0;
        for (int a = 0; a < NPIX; a++) begin
            model[a] = '0;
        end
        $readmemh("dv/raster_stimulus.txt", stim);

        ptr     = 0;
        nframes = 0;
        while (stim[ptr] == 32'd1) begin
            nframes++;
            ptr += 4 + 7 * int'(stim[ptr + 2]) + 3 * int'(stim[ptr + 3]);
        end
        cycle_limit = nframes * (2 * NPIX * (TRI_MAX + 1) + 100);

        wait (rstn);
        @(negedge clk);
        ptr   = 0;
        frame = 0;
        while (stim[ptr] == 32'd1) begin
            bg     = int'(stim[ptr + 1]);
            count  = int'(stim[ptr + 2]);
            nprobe = int'(stim[ptr + 3]);
            ptr += 4;
            for (int a = 0; a < NPIX; a++) begin
                ref_img[a] = 12'(bg);
            end
            for (int t = 0; t < count; t++) begin
                @(negedge clk);
                load_en        = 1'b1;
                load_index     = IDX_W'(t);
                load_tri.a.x   = 8'(stim[ptr]);
                load_tri.a.y   = 8'(stim[ptr + 1]);
                load_tri.b.x   = 8'(stim[ptr + 2]);
                load_tri.b.y   = 8'(stim[ptr + 3]);
                load_tri.c.x   = 8'(stim[ptr + 4]);
                load_tri.c.y   = 8'(stim[ptr + 5]);
                load_tri.color = 12'(stim[ptr + 6]);
                paint_triangle(ptr);
                ptr += 7;
            end
            @(negedge clk);
            load_en    = 1'b0;
            bg_color   = 12'(bg);
            tri_count  = CNT_W'(count);
            draw_start = 1'b1;
            @(negedge clk);
            draw_start = 1'b0;
            while (!frame_done) begin
                @(posedge clk);
            end
            gap = int'($urandom % 4);
            repeat (gap) begin
                @(posedge clk);
                check_value(int'(frame_done), 1, "frame_done held before draw_ack");
            end
            @(negedge clk);
            for (int a = 0; a < NPIX; a++) begin
                check_value(int'(model[a]), int'(ref_img[a]),
                            $sformatf("frame %0d pixel %0d,%0d", frame, a % VIEW_W, a / VIEW_W));
            end
            for (int p = 0; p < nprobe; p++) begin
                px = int'(stim[ptr]);
                py = int'(stim[ptr + 1]);
                check_value(int'(model[py * VIEW_W + px]), int'(stim[ptr + 2]),
                            $sformatf("frame %0d probe %0d,%0d", frame, px, py));
                ptr += 3;
            end
            draw_ack = 1'b1;
            @(negedge clk);
            draw_ack = 1'b0;
            check_value(int'(frame_done), 0, "frame_done after draw_ack");
            frame++;
        end

        $display("Checks done: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
verilog/raster_pkg.sv
verilog/tri_if.sv
verilog/pix_if.sv
verilog/triangle_store.sv
verilog/background_fill.sv
verilog/edge_rasterizer.sv
verilog/draw_manager.sv
verilog/raster_top.sv
dv/tb_clock.sv
dv/raster_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module raster_tb -f vlog.f -o raster_sim

output="$(./obj_dir/raster_sim)"
echo "$output"

if echo "$output" | grep -qx "Verification passed"; then
    exit 0
else
    exit 1
fi

/* dv/raster_stimulus.txt */
// Frame: 1 bg_color tri_count probe_count, then tri_count triangle lines and the probe lines
// Triangle: ax ay bx by cx cy color    Probe: x y expected_color    Last word 0 ends the list
1 00F 3 4
01 01 08 01 01 08 F00
0E 01 09 06 0E 0A 0F0
06 06 1E 08 0A 28 FF0
02 02 F00
0D 05 0F0
0C 0A FF0
00 0B 00F
1 888 0 1
02 02 888
1 000 1 4
03 09 07 02 0C 09 0AF
07 07 0AF
0D 05 000
0C 0A 000
02 02 000
1 333 2 3
00 00 0F 00 00 0B 111
02 02 0C 02 02 08 222
03 03 222
0E 00 111
0F 0B 333
0
